// ==== design/axi_lite_mux_config.svh ====
// --------------------
// Build-time settings for the AXI4-Lite multiplexer
// Included by the package and by every RTL module that sizes ports
// Port count and outstanding limit may be changed here
// --------------------
`ifndef AXI_LITE_MUX_CONFIG_SVH
`define AXI_LITE_MUX_CONFIG_SVH

// Number of upstream manager ports
`define MUX_NUM_PORTS 4

// Routing FIFO depth, also the outstanding limit per direction
`define MUX_MAX_TRANS 4

// Channel widths
`define MUX_ADDR_WIDTH 16
`define MUX_DATA_WIDTH 32

`endif

// ==== design/axi_lite_mux_pkg.sv ====
// --------------------
// Types shared by the multiplexer and its testbench
// Channel payloads, bundled request and response structs, AW FSM states
// --------------------
`default_nettype none

`include "axi_lite_mux_config.svh"

package axi_lite_mux_pkg;

  // Width types
  typedef logic [`MUX_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`MUX_DATA_WIDTH-1:0]   data_t;
  typedef logic [`MUX_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [2:0]                   prot_t;
  // 0 OKAY, 2 SLVERR
  typedef logic [1:0]                   axi_resp_t;
  // At least one bit, also for a single port
  typedef logic [((`MUX_NUM_PORTS > 1) ? $clog2(`MUX_NUM_PORTS) : 1)-1:0] port_idx_t;

  // --------------------
  // Channel payloads
  // --------------------
  // AW and AR carry the same fields
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } addr_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    axi_resp_t resp;
  } b_chan_t;

  typedef struct packed {
    data_t     data;
    axi_resp_t resp;
  } r_chan_t;

  // Everything the manager drives
  typedef struct packed {
    addr_chan_t aw;
    logic       aw_valid;
    w_chan_t    w;
    logic       w_valid;
    logic       b_ready;
    addr_chan_t ar;
    logic       ar_valid;
    logic       r_ready;
  } lite_req_t;

  // Everything the subordinate drives
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } lite_rsp_t;

  // AW offer state, HELD means the W FIFO already has the index
  typedef enum logic {
    AW_IDLE,
    AW_HELD
  } aw_state_t;

endpackage

`default_nettype wire

// ==== design/select_fifo.sv ====
// --------------------
// Small FIFO of upstream port indices
// Remembers routing decisions until the matching beat or response
// Depth is the outstanding limit, no fall-through
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_mux_config.svh"

module select_fifo (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        push_i,
  input  axi_lite_mux_pkg::port_idx_t data_i,
  input  logic                        pop_i,
  output axi_lite_mux_pkg::port_idx_t data_o,
  output logic                        full_o,
  output logic                        empty_o
);

  // Pointer and fill count widths
  typedef logic [((`MUX_MAX_TRANS > 1) ? $clog2(`MUX_MAX_TRANS) : 1)-1:0] ptr_t;
  typedef logic [$clog2(`MUX_MAX_TRANS + 1)-1:0] count_t;

  axi_lite_mux_pkg::port_idx_t mem_q [`MUX_MAX_TRANS];

  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;

  assign full_o  = (count_q == count_t'(`MUX_MAX_TRANS));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // --------------------
  // Pointers and fill count
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        // Wrap at depth, which need not be a power of two
        wr_ptr_q <= (wr_ptr_q == ptr_t'(`MUX_MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(`MUX_MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage only, contents are qualified by the count
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Callers gate push and pop with the flags
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== design/rr_arbiter.sv ====
// --------------------
// Round-robin arbiter for one address channel
// Valid/ready on both sides with the choice locked while stalled
// Search starts after the last granted port
// Port 0 goes first after reset
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_mux_config.svh"

module rr_arbiter (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  input  logic                       [`MUX_NUM_PORTS-1:0]  req_i,
  input  axi_lite_mux_pkg::addr_chan_t [`MUX_NUM_PORTS-1:0] data_i,
  input  logic                                             ready_i,
  output logic                       [`MUX_NUM_PORTS-1:0]  grant_o,
  output logic                                             valid_o,
  output axi_lite_mux_pkg::addr_chan_t                     data_o,
  output axi_lite_mux_pkg::port_idx_t                      idx_o
);

  // Last granted port or the locked winner while stalled
  axi_lite_mux_pkg::port_idx_t idx_q;
  logic                        lock_q;
  axi_lite_mux_pkg::port_idx_t rr_idx;

  // --------------------
  // Round-robin search
  // --------------------
  always_comb begin
    int unsigned cand;
    rr_idx = idx_q;
    // Walk ports after idx_q, ending on idx_q itself
    for (int k = `MUX_NUM_PORTS; k >= 1; k--) begin
      cand = (int'(idx_q) + k) % `MUX_NUM_PORTS;
      if (req_i[cand]) begin
        rr_idx = axi_lite_mux_pkg::port_idx_t'(cand);
      end
    end
  end

  // Locked choice wins over a fresh search
  assign idx_o   = lock_q ? idx_q : rr_idx;
  // No request at all leaves rr_idx on an idle port
  assign valid_o = req_i[idx_o];
  assign data_o  = data_i[idx_o];

  for (genvar i = 0; i < `MUX_NUM_PORTS; i++) begin : gen_grant
    assign grant_o[i] = valid_o & ready_i & (idx_o == axi_lite_mux_pkg::port_idx_t'(i));
  end

  // --------------------
  // Lock and priority state
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Next search starts at port 0
      idx_q  <= axi_lite_mux_pkg::port_idx_t'(`MUX_NUM_PORTS - 1);
      lock_q <= 1'b0;
    end else if (valid_o) begin
      idx_q  <= idx_o;
      // Stay locked until the downstream side takes it
      lock_q <= !ready_i;
    end
  end

  // A stalled winner keeps its grant, its request and its payload
  a_locked_idx_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i) |=> (valid_o && (idx_o == $past(idx_o)) && $stable(data_o)));

endmodule

`default_nettype wire

// ==== design/write_path.sv ====
// --------------------
// Write side of the multiplexer
// AW goes through the arbiter, W follows the AW order via a FIFO
// B is steered back by a second FIFO filled on each W beat
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_mux_config.svh"

module write_path (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  axi_lite_mux_pkg::addr_chan_t [`MUX_NUM_PORTS-1:0] aw_i,
  input  logic                         [`MUX_NUM_PORTS-1:0] aw_valid_i,
  output logic                         [`MUX_NUM_PORTS-1:0] aw_ready_o,
  input  axi_lite_mux_pkg::w_chan_t    [`MUX_NUM_PORTS-1:0] w_i,
  input  logic                         [`MUX_NUM_PORTS-1:0] w_valid_i,
  output logic                         [`MUX_NUM_PORTS-1:0] w_ready_o,
  output axi_lite_mux_pkg::b_chan_t    [`MUX_NUM_PORTS-1:0] b_o,
  output logic                         [`MUX_NUM_PORTS-1:0] b_valid_o,
  input  logic                         [`MUX_NUM_PORTS-1:0] b_ready_i,
  output axi_lite_mux_pkg::addr_chan_t                      down_aw_o,
  output logic                                              down_aw_valid_o,
  input  logic                                              down_aw_ready_i,
  output axi_lite_mux_pkg::w_chan_t                         down_w_o,
  output logic                                              down_w_valid_o,
  input  logic                                              down_w_ready_i,
  input  axi_lite_mux_pkg::b_chan_t                         down_b_i,
  input  logic                                              down_b_valid_i,
  output logic                                              down_b_ready_o
);

  axi_lite_mux_pkg::aw_state_t state_q, state_d;
  axi_lite_mux_pkg::port_idx_t aw_sel, w_sel, b_sel;

  logic aw_valid, aw_ready;
  logic w_full, w_empty, w_push, w_pop;
  logic b_full, b_empty, b_pop;
  logic w_route;

  // --------------------
  // AW channel
  // --------------------
  rr_arbiter i_aw_arbiter (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .req_i   ( aw_valid_i ),
    .data_i  ( aw_i       ),
    .ready_i ( aw_ready   ),
    .grant_o ( aw_ready_o ),
    .valid_o ( aw_valid   ),
    .data_o  ( down_aw_o  ),
    .idx_o   ( aw_sel     )
  );

  // Offer AW only with W FIFO room, push once per write
  always_comb begin
    state_d         = state_q;
    w_push          = 1'b0;
    down_aw_valid_o = 1'b0;
    aw_ready        = 1'b0;
    case (state_q)
      axi_lite_mux_pkg::AW_IDLE: begin
        if (aw_valid && !w_full) begin
          down_aw_valid_o = 1'b1;
          w_push          = 1'b1;
          if (down_aw_ready_i) begin
            aw_ready = 1'b1;
          end else begin
            state_d = axi_lite_mux_pkg::AW_HELD;
          end
        end
      end
      // Index already queued, keep offering
      axi_lite_mux_pkg::AW_HELD: begin
        down_aw_valid_o = 1'b1;
        if (down_aw_ready_i) begin
          aw_ready = 1'b1;
          state_d  = axi_lite_mux_pkg::AW_IDLE;
        end
      end
      default: state_d = axi_lite_mux_pkg::AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= axi_lite_mux_pkg::AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  select_fifo i_w_fifo (
    .clk_i   ( clk_i   ),
    .rst_i   ( rst_i   ),
    .push_i  ( w_push  ),
    .data_i  ( aw_sel  ),
    .pop_i   ( w_pop   ),
    .data_o  ( w_sel   ),
    .full_o  ( w_full  ),
    .empty_o ( w_empty )
  );

  // --------------------
  // W channel
  // --------------------
  // Needs a queued AW and room for the B index
  assign w_route        = !w_empty && !b_full;
  assign down_w_o       = w_i[w_sel];
  assign down_w_valid_o = w_route & w_valid_i[w_sel];
  assign w_pop          = down_w_valid_o & down_w_ready_i;

  for (genvar i = 0; i < `MUX_NUM_PORTS; i++) begin : gen_w_ready
    assign w_ready_o[i] = down_w_ready_i & w_route &
                          (w_sel == axi_lite_mux_pkg::port_idx_t'(i));
  end

  select_fifo i_b_fifo (
    .clk_i   ( clk_i   ),
    .rst_i   ( rst_i   ),
    .push_i  ( w_pop   ),
    .data_i  ( w_sel   ),
    .pop_i   ( b_pop   ),
    .data_o  ( b_sel   ),
    .full_o  ( b_full  ),
    .empty_o ( b_empty )
  );

  // --------------------
  // B channel
  // --------------------
  assign down_b_ready_o = !b_empty & b_ready_i[b_sel];
  assign b_pop          = down_b_valid_i & down_b_ready_o;

  for (genvar i = 0; i < `MUX_NUM_PORTS; i++) begin : gen_b_out
    assign b_o[i]       = down_b_i;
    assign b_valid_o[i] = down_b_valid_i & !b_empty &
                          (b_sel == axi_lite_mux_pkg::port_idx_t'(i));
  end

  // Stalled AW holds valid and payload, through the FSM and the arbiter lock
  a_aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (down_aw_valid_o && !down_aw_ready_i) |=> (down_aw_valid_o && $stable(down_aw_o)));

endmodule

`default_nettype wire

// ==== design/read_path.sv ====
// --------------------
// Read side of the multiplexer
// AR is arbitrated and gated by R FIFO room
// R returns in order to the port named at the FIFO head
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_mux_config.svh"

module read_path (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  axi_lite_mux_pkg::addr_chan_t [`MUX_NUM_PORTS-1:0] ar_i,
  input  logic                         [`MUX_NUM_PORTS-1:0] ar_valid_i,
  output logic                         [`MUX_NUM_PORTS-1:0] ar_ready_o,
  output axi_lite_mux_pkg::r_chan_t    [`MUX_NUM_PORTS-1:0] r_o,
  output logic                         [`MUX_NUM_PORTS-1:0] r_valid_o,
  input  logic                         [`MUX_NUM_PORTS-1:0] r_ready_i,
  output axi_lite_mux_pkg::addr_chan_t                      down_ar_o,
  output logic                                              down_ar_valid_o,
  input  logic                                              down_ar_ready_i,
  input  axi_lite_mux_pkg::r_chan_t                         down_r_i,
  input  logic                                              down_r_valid_i,
  output logic                                              down_r_ready_o
);

  axi_lite_mux_pkg::port_idx_t ar_sel, r_sel;

  logic ar_valid, ar_ready;
  logic r_full, r_empty, r_push, r_pop;

  // --------------------
  // AR channel
  // --------------------
  rr_arbiter i_ar_arbiter (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .req_i   ( ar_valid_i ),
    .data_i  ( ar_i       ),
    .ready_i ( ar_ready   ),
    .grant_o ( ar_ready_o ),
    .valid_o ( ar_valid   ),
    .data_o  ( down_ar_o  ),
    .idx_o   ( ar_sel     )
  );

  // Full R FIFO blocks both sides, no hold state needed here
  // since the index is only pushed on the transfer itself
  assign down_ar_valid_o = ar_valid & !r_full;
  assign ar_ready        = down_ar_ready_i & !r_full;
  assign r_push          = down_ar_valid_o & down_ar_ready_i;

  select_fifo i_r_fifo (
    .clk_i   ( clk_i   ),
    .rst_i   ( rst_i   ),
    .push_i  ( r_push  ),
    .data_i  ( ar_sel  ),
    .pop_i   ( r_pop   ),
    .data_o  ( r_sel   ),
    .full_o  ( r_full  ),
    .empty_o ( r_empty )
  );

  // --------------------
  // R channel
  // --------------------
  assign down_r_ready_o = !r_empty & r_ready_i[r_sel];
  assign r_pop          = down_r_valid_i & down_r_ready_o;

  for (genvar i = 0; i < `MUX_NUM_PORTS; i++) begin : gen_r_out
    assign r_o[i]       = down_r_i;
    assign r_valid_o[i] = down_r_valid_i & !r_empty &
                          (r_sel == axi_lite_mux_pkg::port_idx_t'(i));
  end

  // R FIFO stays full until an R transfer frees a slot
  a_ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (down_ar_valid_o && !down_ar_ready_i && !r_pop) |=>
      (down_ar_valid_o && $stable(down_ar_o)));

endmodule

`default_nettype wire

// ==== design/axi_lite_mux.sv ====
// --------------------
// AXI4-Lite multiplexer top level
// Joins the upstream manager ports onto one downstream port
// Unpacks the bundled structs and hands channels to both paths
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_mux_config.svh"

module axi_lite_mux (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  input  axi_lite_mux_pkg::lite_req_t [`MUX_NUM_PORTS-1:0] up_req_i,
  output axi_lite_mux_pkg::lite_rsp_t [`MUX_NUM_PORTS-1:0] up_rsp_o,
  output axi_lite_mux_pkg::lite_req_t                      down_req_o,
  input  axi_lite_mux_pkg::lite_rsp_t                      down_rsp_i
);

  // Per-channel views of the upstream structs
  axi_lite_mux_pkg::addr_chan_t [`MUX_NUM_PORTS-1:0] aw, ar;
  axi_lite_mux_pkg::w_chan_t    [`MUX_NUM_PORTS-1:0] w;
  axi_lite_mux_pkg::b_chan_t    [`MUX_NUM_PORTS-1:0] b;
  axi_lite_mux_pkg::r_chan_t    [`MUX_NUM_PORTS-1:0] r;

  logic [`MUX_NUM_PORTS-1:0] aw_valid, aw_ready, w_valid, w_ready;
  logic [`MUX_NUM_PORTS-1:0] b_valid, b_ready;
  logic [`MUX_NUM_PORTS-1:0] ar_valid, ar_ready, r_valid, r_ready;

  for (genvar i = 0; i < `MUX_NUM_PORTS; i++) begin : gen_port
    assign aw[i]       = up_req_i[i].aw;
    assign aw_valid[i] = up_req_i[i].aw_valid;
    assign w[i]        = up_req_i[i].w;
    assign w_valid[i]  = up_req_i[i].w_valid;
    assign b_ready[i]  = up_req_i[i].b_ready;
    assign ar[i]       = up_req_i[i].ar;
    assign ar_valid[i] = up_req_i[i].ar_valid;
    assign r_ready[i]  = up_req_i[i].r_ready;

    assign up_rsp_o[i].aw_ready = aw_ready[i];
    assign up_rsp_o[i].w_ready  = w_ready[i];
    assign up_rsp_o[i].b        = b[i];
    assign up_rsp_o[i].b_valid  = b_valid[i];
    assign up_rsp_o[i].ar_ready = ar_ready[i];
    assign up_rsp_o[i].r        = r[i];
    assign up_rsp_o[i].r_valid  = r_valid[i];
  end

  write_path i_write_path (
    .clk_i           ( clk_i                  ),
    .rst_i           ( rst_i                  ),
    .aw_i            ( aw                     ),
    .aw_valid_i      ( aw_valid               ),
    .aw_ready_o      ( aw_ready               ),
    .w_i             ( w                      ),
    .w_valid_i       ( w_valid                ),
    .w_ready_o       ( w_ready                ),
    .b_o             ( b                      ),
    .b_valid_o       ( b_valid                ),
    .b_ready_i       ( b_ready                ),
    .down_aw_o       ( down_req_o.aw          ),
    .down_aw_valid_o ( down_req_o.aw_valid    ),
    .down_aw_ready_i ( down_rsp_i.aw_ready    ),
    .down_w_o        ( down_req_o.w           ),
    .down_w_valid_o  ( down_req_o.w_valid     ),
    .down_w_ready_i  ( down_rsp_i.w_ready     ),
    .down_b_i        ( down_rsp_i.b           ),
    .down_b_valid_i  ( down_rsp_i.b_valid     ),
    .down_b_ready_o  ( down_req_o.b_ready     )
  );

  read_path i_read_path (
    .clk_i           ( clk_i                  ),
    .rst_i           ( rst_i                  ),
    .ar_i            ( ar                     ),
    .ar_valid_i      ( ar_valid               ),
    .ar_ready_o      ( ar_ready               ),
    .r_o             ( r                      ),
    .r_valid_o       ( r_valid                ),
    .r_ready_i       ( r_ready                ),
    .down_ar_o       ( down_req_o.ar          ),
    .down_ar_valid_o ( down_req_o.ar_valid    ),
    .down_ar_ready_i ( down_rsp_i.ar_ready    ),
    .down_r_i        ( down_rsp_i.r           ),
    .down_r_valid_i  ( down_rsp_i.r_valid     ),
    .down_r_ready_o  ( down_req_o.r_ready     )
  );

endmodule

`default_nettype wire

// ==== test/lite_mem_model.sv ====
// --------------------
// Downstream AXI4-Lite memory for the multiplexer testbench
// 16 words with OKAY below address 64 and SLVERR above
// Random readies and response delays
// Takes one write and one read at a time
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_mux_config.svh"

module lite_mem_model (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  axi_lite_mux_pkg::lite_req_t req_i,
  output axi_lite_mux_pkg::lite_rsp_t rsp_o
);

  localparam logic [31:0] SEED = 32'h0cf0_22b2;

  axi_lite_mux_pkg::data_t     mem_q [16];
  axi_lite_mux_pkg::addr_t     aw_addr_q, ar_addr_q;
  axi_lite_mux_pkg::w_chan_t   w_q;
  axi_lite_mux_pkg::axi_resp_t b_resp_q;
  axi_lite_mux_pkg::r_chan_t   r_q;
  logic [31:0] lfsr_q;
  // 0 AW ready, 1 W ready, 2 AR ready, 3 B delay, 4 R delay
  logic [4:0]  rnd_q;
  logic        aw_have_q, w_have_q, ar_have_q, b_valid_q, r_valid_q;

  // Galois LFSR stepped once per random bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  assign rsp_o.aw_ready = rnd_q[0] & !aw_have_q & !b_valid_q;
  assign rsp_o.w_ready  = rnd_q[1] & !w_have_q & !b_valid_q;
  assign rsp_o.ar_ready = rnd_q[2] & !ar_have_q & !r_valid_q;
  assign rsp_o.b.resp   = b_resp_q;
  assign rsp_o.b_valid  = b_valid_q;
  assign rsp_o.r        = r_q;
  assign rsp_o.r_valid  = r_valid_q;

  always @(posedge clk_i) begin : seq
    logic [31:0] l;
    logic [4:0]  bits;
    l = lfsr_q;
    for (int k = 0; k < 5; k++) begin
      l = lfsr_step(l);
      bits[k] = l[0];
    end
    if (rst_i) begin
      lfsr_q    <= SEED;
      rnd_q     <= '0;
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
      ar_have_q <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
      for (int i = 0; i < 16; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      lfsr_q <= l;
      rnd_q  <= bits;
      if (req_i.aw_valid && rsp_o.aw_ready) begin
        aw_have_q <= 1'b1;
        aw_addr_q <= req_i.aw.addr;
      end
      if (req_i.w_valid && rsp_o.w_ready) begin
        w_have_q <= 1'b1;
        w_q      <= req_i.w;
      end
      // Commit once both halves of the write are in
      if (aw_have_q && w_have_q && !b_valid_q && rnd_q[3]) begin
        if (aw_addr_q < 64) begin
          for (int j = 0; j < `MUX_DATA_WIDTH / 8; j++) begin
            if (w_q.strb[j]) begin
              mem_q[aw_addr_q[5:2]][8*j +: 8] <= w_q.data[8*j +: 8];
            end
          end
          b_resp_q <= 2'd0;
        end else begin
          b_resp_q <= 2'd2;
        end
        b_valid_q <= 1'b1;
        aw_have_q <= 1'b0;
        w_have_q  <= 1'b0;
      end
      if (b_valid_q && req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      // Read side
      if (req_i.ar_valid && rsp_o.ar_ready) begin
        ar_have_q <= 1'b1;
        ar_addr_q <= req_i.ar.addr;
      end
      if (ar_have_q && !r_valid_q && rnd_q[4]) begin
        r_q.data  <= (ar_addr_q < 64) ? mem_q[ar_addr_q[5:2]] : '0;
        r_q.resp  <= (ar_addr_q < 64) ? 2'd0 : 2'd2;
        r_valid_q <= 1'b1;
        ar_have_q <= 1'b0;
      end
      if (r_valid_q && req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_axi_lite_mux.sv ====
// --------------------
// Testbench for the AXI4-Lite multiplexer
// Runs a table of accesses in groups that start on their ports together
// Monitors arbitration order, payload hold and the read limit
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_mux_config.svh"

module tb_axi_lite_mux;

  localparam int NP          = `MUX_NUM_PORTS;
  localparam int NUM_TESTS   = 18;
  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;

  typedef struct packed {
    logic [3:0]                  group;
    axi_lite_mux_pkg::port_idx_t port;
    logic                        wr;
    logic                        rr;
    axi_lite_mux_pkg::addr_t     addr;
    axi_lite_mux_pkg::data_t     data;
    axi_lite_mux_pkg::data_t     exp_data;
    axi_lite_mux_pkg::axi_resp_t exp_resp;
  } test_t;

  logic clk;
  logic rst_i;
  axi_lite_mux_pkg::lite_req_t [NP-1:0] up_req;
  axi_lite_mux_pkg::lite_rsp_t [NP-1:0] up_rsp;
  axi_lite_mux_pkg::lite_req_t          down_req;
  axi_lite_mux_pkg::lite_rsp_t          down_rsp;

  test_t tests [NUM_TESTS];
  string names [NUM_TESTS];
  logic  rr_active;
  int    rr_expect;
  int    rd_count;
  logic  aw_stall_q, ar_stall_q;
  axi_lite_mux_pkg::addr_chan_t aw_prev_q, ar_prev_q;

  axi_lite_mux uut (
    .clk_i      ( clk      ),
    .rst_i      ( rst_i    ),
    .up_req_i   ( up_req   ),
    .up_rsp_o   ( up_rsp   ),
    .down_req_o ( down_req ),
    .down_rsp_i ( down_rsp )
  );

  lite_mem_model i_mem (
    .clk_i ( clk      ),
    .rst_i ( rst_i    ),
    .req_i ( down_req ),
    .rsp_o ( down_rsp )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Downstream valids, then upstream B and R valids
  function automatic logic [63:0] collect_valids();
    logic [63:0] v;
    v    = '0;
    v[0] = down_req.aw_valid;
    v[1] = down_req.w_valid;
    v[2] = down_req.ar_valid;
    for (int p = 0; p < NP; p++) begin
      v[3+p]    = up_rsp[p].b_valid;
      v[3+NP+p] = up_rsp[p].r_valid;
    end
    return v;
  endfunction

  task automatic set_entry(input int i, input string name, input int grp, input int port,
                           input bit wr, input bit rr, input int addr,
                           input logic [31:0] data, input logic [31:0] exp_data,
                           input logic [1:0] resp);
    names[i]          = name;
    tests[i].group    = 4'(grp);
    tests[i].port     = axi_lite_mux_pkg::port_idx_t'(port);
    tests[i].wr       = wr;
    tests[i].rr       = rr;
    tests[i].addr     = axi_lite_mux_pkg::addr_t'(addr);
    tests[i].data     = data;
    tests[i].exp_data = exp_data;
    tests[i].exp_resp = resp;
  endtask

  task automatic load_table();
    for (int p = 0; p < NP; p++) begin
      // Word index in bits 5:2 equals the port for the arbitration check
      if (p < NP - 1) begin
        set_entry(p, "rr_write_a", 0, p, 1, 1, 4 * p, 32'h1000_0000 + p, 0, 2'd0);
      end else begin
        // Last port reads instead so that the next group starts mid-rotation
        set_entry(p, "reset_word_read", 0, p, 0, 1, 4 * p, 0, 0, 2'd0);
      end
      set_entry(NP + p, "rr_write_b", 1, p, 1, 1, 4 * p, 32'ha5a5_0000 + 17 * p, 0, 2'd0);
      set_entry(2 * NP + p, "concurrent_read", 2, p, 0, 0, 4 * p, 0,
                32'ha5a5_0000 + 17 * p, 2'd0);
    end
    set_entry(12, "single_write", 3, 1, 1, 0, 'h20, 32'hcafe_0120, 0, 2'd0);
    set_entry(13, "single_read", 4, 1, 0, 0, 'h20, 0, 32'hcafe_0120, 2'd0);
    set_entry(14, "word9_write", 5, 3, 1, 0, 'h24, 32'h1234_5678, 0, 2'd0);
    set_entry(15, "error_write", 6, 2, 1, 0, 'h64, 32'hdead_beef, 0, 2'd2);
    set_entry(16, "error_read", 7, 2, 0, 0, 'h64, 0, 0, 2'd2);
    set_entry(17, "word9_unchanged", 8, 0, 0, 0, 'h24, 0, 32'h1234_5678, 2'd0);
  endtask

  // Runs entries first to last with one per port until every response is back
  task automatic run_group(input int first, input int last);
    logic [NP-1:0] pend_aw, pend_w, pend_b, pend_ar, pend_r;
    int            idx [NP];
    int            p;
    pend_aw = '0;
    pend_w  = '0;
    pend_b  = '0;
    pend_ar = '0;
    pend_r  = '0;
    for (int k = 0; k < NP; k++) begin
      idx[k] = first;
    end
    for (int e = first; e <= last; e++) begin
      p = int'(tests[e].port);
      idx[p] = e;
      if (tests[e].wr) begin
        pend_aw[p] = 1'b1;
        pend_w[p]  = 1'b1;
        pend_b[p]  = 1'b1;
      end else begin
        pend_ar[p] = 1'b1;
        pend_r[p]  = 1'b1;
      end
    end
    rr_active = tests[first].rr;
    while (|{pend_aw, pend_w, pend_b, pend_ar, pend_r}) begin
      @(posedge clk);
      #DRIVE_DELAY;
      for (int k = 0; k < NP; k++) begin
        up_req[k].aw.addr  = tests[idx[k]].addr;
        up_req[k].aw.prot  = '0;
        up_req[k].aw_valid = pend_aw[k];
        up_req[k].w.data   = tests[idx[k]].data;
        up_req[k].w.strb   = '1;
        up_req[k].w_valid  = pend_w[k];
        up_req[k].b_ready  = 1'b1;
        up_req[k].ar.addr  = tests[idx[k]].addr;
        up_req[k].ar.prot  = '0;
        up_req[k].ar_valid = pend_ar[k];
        up_req[k].r_ready  = 1'b1;
      end
      // Handshakes of the coming edge are settled by mid-cycle
      @(negedge clk);
      for (int k = 0; k < NP; k++) begin
        if (up_req[k].aw_valid && up_rsp[k].aw_ready) pend_aw[k] = 1'b0;
        if (up_req[k].w_valid && up_rsp[k].w_ready) pend_w[k] = 1'b0;
        if (up_req[k].ar_valid && up_rsp[k].ar_ready) pend_ar[k] = 1'b0;
        if (up_rsp[k].b_valid) begin
          check_value("unexpected_b_valid", 1, pend_b[k]);
          check_value(names[idx[k]], tests[idx[k]].exp_resp, up_rsp[k].b.resp);
          pend_b[k] = 1'b0;
        end
        if (up_rsp[k].r_valid) begin
          check_value("unexpected_r_valid", 1, pend_r[k]);
          check_value(names[idx[k]], tests[idx[k]].exp_resp, up_rsp[k].r.resp);
          check_value(names[idx[k]], tests[idx[k]].exp_data, up_rsp[k].r.data);
          pend_r[k] = 1'b0;
        end
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    up_req    = '0;
    rr_active = 1'b0;
  endtask

  // --------------------
  // Downstream monitor
  // --------------------
  always @(negedge clk) begin
    if (rst_i) begin
      rd_count   = 0;
      aw_stall_q = 1'b0;
      ar_stall_q = 1'b0;
    end else begin
      // Stalled address payloads must hold
      if (aw_stall_q) begin
        check_value("aw_hold_valid", 1, down_req.aw_valid);
        check_value("aw_hold_payload", aw_prev_q, down_req.aw);
      end
      if (ar_stall_q) begin
        check_value("ar_hold_valid", 1, down_req.ar_valid);
        check_value("ar_hold_payload", ar_prev_q, down_req.ar);
      end
      aw_stall_q = down_req.aw_valid && !down_rsp.aw_ready;
      ar_stall_q = down_req.ar_valid && !down_rsp.ar_ready;
      aw_prev_q  = down_req.aw;
      ar_prev_q  = down_req.ar;
      if (down_req.ar_valid && down_rsp.ar_ready) rd_count++;
      if (down_rsp.r_valid && down_req.r_ready) rd_count--;
      check_value("read_limit", 1, rd_count <= `MUX_MAX_TRANS);
      if (rr_active && down_req.aw_valid && down_rsp.aw_ready) begin
        check_value("round_robin", rr_expect, down_req.aw.addr[5:2]);
        rr_expect = (rr_expect + 1) % NP;
      end
    end
  end

  // Watchdog sized from the table length
  initial begin
    #((16 + 200 * NUM_TESTS) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int i;
    int j;
    clk       = 1'b0;
    rst_i     = 1'b1;
    up_req    = '0;
    rr_active = 1'b0;
    rr_expect = 0;
    load_table();
    repeat (15) begin
      @(negedge clk);
      check_value("reset_valids", 0, collect_valids());
    end
    @(posedge clk);
    #DRIVE_DELAY;
    rst_i = 1'b0;
    @(negedge clk);
    check_value("after_reset_valids", 0, collect_valids());
    i = 0;
    while (i < NUM_TESTS) begin
      j = i;
      while (j + 1 < NUM_TESTS && tests[j+1].group == tests[i].group) begin
        j++;
      end
      run_group(i, j);
      i = j + 1;
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/axi_lite_mux_pkg.sv
design/select_fifo.sv
design/rr_arbiter.sv
design/write_path.sv
design/read_path.sv
design/axi_lite_mux.sv
test/lite_mem_model.sv
test/tb_axi_lite_mux.sv

// ==== Bender.yml ====
package:
  name: axi_lite_mux

sources:
  - include_dirs:
      - design
    files:
      - design/axi_lite_mux_pkg.sv
      - design/select_fifo.sv
      - design/rr_arbiter.sv
      - design/write_path.sv
      - design/read_path.sv
      - design/axi_lite_mux.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/lite_mem_model.sv
      - test/tb_axi_lite_mux.sv
